// File: sdProbePkg.sv
package sdProbePkg;

    // ==========================================================
    // Vector types
    // ==========================================================

    // One bit per SD data line (DAT3 down to DAT0)
    typedef logic [3:0] sdDat_t;

    // Board LEDs
    typedef logic [2:0] led_t;

    // Phase lengths in ticks and the clock divider count
    typedef logic [31:0] tickCount_t;

    // ==========================================================
    // Pin levels toward the card
    // ==========================================================

    typedef struct packed {
        logic   pwrEn;
        logic   sdClk;
        logic   cmdOut;
        logic   cmdOe;
        sdDat_t datOut;
        sdDat_t datOe;
    } sdPins_t;

    // ==========================================================
    // Power and LVS probe sequence
    // ==========================================================

    typedef enum logic [2:0] {
        PowerOff,
        PowerSettle,
        ClkHigh,
        ClkLow,
        Release,
        Sample
    } seqState_t;

endpackage

// File: sdTickGen.sv
`timescale 1ns/1ns

module sdTickGen import sdProbePkg::*; #(
    parameter tickCount_t ClkDiv = 32'd64
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // ==========================================================
    // SD bus rate divider
    // ==========================================================

    // Count value on the cycle that carries the tick
    localparam tickCount_t LastCount = ClkDiv - tickCount_t'(1);

    tickCount_t divCount;

    // One clk cycle wide, once per ClkDiv cycles
    assign tick = (divCount == LastCount);

    always_ff @(posedge clk) begin
        if (reset) begin
            divCount <= '0;
        end else if (tick) begin
            // Wrap and start the next tick period
            divCount <= '0;
        end else begin
            divCount <= divCount + tickCount_t'(1);
        end
    end

endmodule

// File: sdPowerSequencer.sv
`timescale 1ns/1ns

module sdPowerSequencer import sdProbePkg::*; #(
    parameter tickCount_t PowerOffTicks = 32'd375000,
    parameter tickCount_t SettleTicks   = 32'd18750,
    parameter tickCount_t PulseTicks    = 32'd12
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    tick,
    input  sdDat_t  datIn,
    output sdPins_t pins,
    output led_t    led
);

    // ==========================================================
    // Constants
    // ==========================================================

    // Card unpowered, CMD and DAT held low
    // DAT2 left floating, the board pull-down keeps it low
    localparam sdPins_t OffPins = '{
        pwrEn:  1'b0,
        sdClk:  1'b0,
        cmdOut: 1'b0,
        cmdOe:  1'b1,
        datOut: 4'b0000,
        datOe:  4'b1011
    };

    localparam led_t LedAllOn  = 3'b111;
    localparam led_t LedAllOff = 3'b000;

    // Release lasts a single tick
    localparam tickCount_t ReleaseTicks = 32'd1;

    // Data line that reports the card's signalling level
    localparam int Dat2 = 2;

    // ==========================================================
    // Signals
    // ==========================================================

    seqState_t  state;
    seqState_t  stateNext;
    tickCount_t delayCount;
    tickCount_t delayNext;
    sdPins_t    pinsNext;
    led_t       ledNext;
    logic       phaseDone;
    logic [1:0] datSync;

    // ==========================================================
    // DAT2 synchronizer
    // ==========================================================

    // datIn comes straight off the pad, asynchronous to clk
    always_ff @(posedge clk) begin
        if (reset) begin
            datSync <= '0;
        end else begin
            datSync <= {datSync[0], datIn[Dat2]};
        end
    end

    // ==========================================================
    // Phase sequencing
    // ==========================================================

    // Last tick of the current phase
    // A zero length behaves like a single tick
    assign phaseDone = (delayCount <= tickCount_t'(1));

    always_comb begin
        stateNext = state;
        delayNext = delayCount;
        pinsNext  = pins;
        ledNext   = led;

        if (tick) begin
            if (state == Sample) begin
                // Mirror the card's DAT2 level on LED 0
                ledNext[0] = datSync[1];
            end else if (!phaseDone) begin
                delayNext = delayCount - tickCount_t'(1);
            end else begin
                // Outputs of the next phase load on its first edge
                case (state)
                    PowerOff: begin
                        stateNext      = PowerSettle;
                        delayNext      = SettleTicks;
                        pinsNext.pwrEn = 1'b1;
                        ledNext        = LedAllOff;
                    end

                    PowerSettle: begin
                        // Start of the LVS identification pulse
                        stateNext      = ClkHigh;
                        delayNext      = PulseTicks;
                        pinsNext.sdClk = 1'b1;
                    end

                    ClkHigh: begin
                        stateNext      = ClkLow;
                        delayNext      = PulseTicks;
                        pinsNext.sdClk = 1'b0;
                    end

                    ClkLow: begin
                        stateNext = Release;
                        delayNext = ReleaseTicks;
                    end

                    Release: begin
                        // Let go of CMD and DAT, the card drives from now on
                        stateNext      = Sample;
                        pinsNext.cmdOe = 1'b0;
                        pinsNext.datOe = '0;
                    end

                    default: begin
                        stateNext = PowerOff;
                        delayNext = PowerOffTicks;
                        pinsNext  = OffPins;
                        ledNext   = LedAllOn;
                    end
                endcase
            end
        end
    end

    // ==========================================================
    // State and output registers
    // ==========================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= PowerOff;
            delayCount <= PowerOffTicks;
            pins       <= OffPins;
            led        <= LedAllOn;
        end else begin
            state      <= stateNext;
            delayCount <= delayNext;
            pins       <= pinsNext;
            led        <= ledNext;
        end
    end

endmodule

// File: sdProbeTop.sv
`timescale 1ns/1ns

module sdProbeTop import sdProbePkg::*; #(
    parameter tickCount_t ClkDiv        = 32'd64,
    parameter tickCount_t PowerOffTicks = 32'd375000,
    parameter tickCount_t SettleTicks   = 32'd18750,
    parameter tickCount_t PulseTicks    = 32'd12
) (
    input  logic    clk,
    input  logic    reset,
    // CMD input, part of the full pin set, not read by the probe
    input  logic    cmdIn,
    input  sdDat_t  datIn,
    output sdPins_t pins,
    output led_t    led
);

    // ==========================================================
    // Tick enable at the SD bus rate
    // ==========================================================

    logic tick;

    sdTickGen #(
        .ClkDiv(ClkDiv)
    ) tickGen0 (
        .clk(clk),
        .reset(reset),
        .tick(tick)
    );

    // ==========================================================
    // Power-up and LVS probe
    // ==========================================================

    sdPowerSequencer #(
        .PowerOffTicks(PowerOffTicks),
        .SettleTicks(SettleTicks),
        .PulseTicks(PulseTicks)
    ) seq0 (
        .clk(clk),
        .reset(reset),
        .tick(tick),
        .datIn(datIn),
        .pins(pins),
        .led(led)
    );

endmodule

// File: sdProbeTb.sv
`timescale 1ns/1ns

module sdProbeTb import sdProbePkg::*; ();

    // ==========================================================
    // Configuration
    // ==========================================================

    localparam int ClkDivTb        = 4;
    localparam int PowerOffTicksTb = 6;
    localparam int SettleTicksTb   = 5;
    localparam int PulseTicksTb    = 3;

    // Tick index at which each phase ends
    localparam int OffEnd     = PowerOffTicksTb;
    localparam int SettleEnd  = OffEnd + SettleTicksTb;
    localparam int HighEnd    = SettleEnd + PulseTicksTb;
    localparam int LowEnd     = HighEnd + PulseTicksTb;
    localparam int ReleaseEnd = LowEnd + 1;

    localparam int SampleTicks   = 200;
    localparam int TimeoutMargin = 8 * ClkDivTb;
    localparam int ResetCycles   = 10;

    localparam logic [31:0] LfsrSeed = 32'hb9b32d4b;
    localparam logic [31:0] LfsrTaps = 32'h80200003;

    // Card unpowered, CMD and DAT low, DAT2 left to the pull-down
    localparam sdPins_t OffPinsExp = '{
        pwrEn:  1'b0,
        sdClk:  1'b0,
        cmdOut: 1'b0,
        cmdOe:  1'b1,
        datOut: 4'b0000,
        datOe:  4'b1011
    };

    // ==========================================================
    // DUT and clock
    // ==========================================================

    logic    clk;
    logic    reset;
    logic    cmdIn;
    sdDat_t  datIn;
    sdPins_t pins;
    led_t    led;

    sdProbeTop #(
        .ClkDiv(tickCount_t'(ClkDivTb)),
        .PowerOffTicks(tickCount_t'(PowerOffTicksTb)),
        .SettleTicks(tickCount_t'(SettleTicksTb)),
        .PulseTicks(tickCount_t'(PulseTicksTb))
    ) dut0 (
        .clk(clk),
        .reset(reset),
        .cmdIn(cmdIn),
        .datIn(datIn),
        .pins(pins),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // ==========================================================
    // Random numbers
    // ==========================================================

    logic [31:0] lfsrState;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? LfsrTaps : 32'h0);
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        repeat (count) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrStep(lfsrState);
        end
    endtask

    // ==========================================================
    // Failure and compare tasks
    // ==========================================================

    task automatic stopWithFailure();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkPins(input sdPins_t expected, input sdPins_t actual);
        if (actual !== expected) begin
            $display("ERR pins at %0t ns: expected 0x%03h, actual 0x%03h",
                     $time, expected, actual);
            stopWithFailure();
        end
    endtask

    task automatic checkLed(input led_t expected, input led_t actual);
        if (actual !== expected) begin
            $display("ERR led at %0t ns: expected 0x%01h, actual 0x%01h",
                     $time, expected, actual);
            stopWithFailure();
        end
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================

    // Pin levels after a given number of ticks since reset release
    function automatic sdPins_t expectedPins(input int ticks);
        sdPins_t p;
        p = OffPinsExp;
        if (ticks >= OffEnd) begin
            p.pwrEn = 1'b1;
        end
        if (ticks >= SettleEnd && ticks < HighEnd) begin
            p.sdClk = 1'b1;
        end
        if (ticks >= ReleaseEnd) begin
            p.cmdOe = 1'b0;
            p.datOe = '0;
        end
        return p;
    endfunction

    function automatic led_t expectedLed(input int ticks, input logic led0);
        led_t l;
        if (ticks < OffEnd) begin
            l = 3'b111;
        end else begin
            l = {2'b00, led0};
        end
        return l;
    endfunction

    int         edgeCount;
    logic [1:0] modelSync;
    logic       modelLed0;
    logic       modelValid = 1'b0;

    // Edges counted from the first clock with reset low
    // A tick lands on every ClkDivTb-th edge
    always @(posedge clk) begin
        if (reset) begin
            edgeCount = 0;
            modelSync = 2'b00;
            modelLed0 = 1'b0;
        end else begin
            edgeCount = edgeCount + 1;
            if ((edgeCount % ClkDivTb) == 0 && (edgeCount / ClkDivTb) > ReleaseEnd) begin
                modelLed0 = modelSync[1];
            end
            modelSync = {modelSync[0], datIn[2]};
        end
        modelValid = 1'b1;
    end

    // ==========================================================
    // Per-clock checker
    // ==========================================================

    int   sdClkRises = 0;
    int   led0Changes = 0;
    logic lastSdClk = 1'b0;
    logic lastLed0 = 1'b0;

    always @(negedge clk) begin
        if (modelValid) begin
            checkPins(expectedPins(edgeCount / ClkDivTb), pins);
            checkLed(expectedLed(edgeCount / ClkDivTb, modelLed0), led);
            if (pins.sdClk && !lastSdClk) begin
                sdClkRises++;
            end
            if (sdClkRises > 1) begin
                $display("sdClk pulsed more than once in one power-up sequence");
                stopWithFailure();
            end
            if (led[0] != lastLed0 && (edgeCount / ClkDivTb) >= ReleaseEnd) begin
                led0Changes++;
            end
            lastSdClk = pins.sdClk;
            lastLed0 = led[0];
            // New sequence starts after every reset
            if (reset) begin
                sdClkRises = 0;
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    int   holdLeft;
    logic dat2Level;

    // DAT2 level held for 1 to 8 ticks, other inputs change every clock
    initial begin
        logic [31:0] bits;
        lfsrState = LfsrSeed;
        datIn = '0;
        cmdIn = 1'b0;
        holdLeft = 0;
        dat2Level = 1'b0;
        forever begin
            @(posedge clk);
            if (holdLeft == 0) begin
                drawBits(1, bits);
                dat2Level = bits[0];
                drawBits(3, bits);
                holdLeft = (int'(bits[2:0]) + 1) * ClkDivTb;
            end
            holdLeft = holdLeft - 1;
            drawBits(3, bits);
            datIn <= {bits[2], dat2Level, bits[1], bits[0]};
            drawBits(1, bits);
            cmdIn <= bits[0];
        end
    end

    // ==========================================================
    // Sequence tasks
    // ==========================================================

    task automatic releaseReset();
        reset <= 1'b0;
        @(negedge clk);
    endtask

    // Waits for the pins to leave a phase and checks its length in clocks
    task automatic timePhase(input string nextPhase, input sdPins_t phasePins,
                             input int expectClocks);
        int clocks;
        bit ended;
        clocks = 0;
        ended = 1'b0;
        while (!ended && clocks < expectClocks + TimeoutMargin) begin
            @(negedge clk);
            clocks++;
            if (pins != phasePins) begin
                ended = 1'b1;
            end
        end
        if (!ended) begin
            $display("Timeout: the %s phase never came", nextPhase);
            stopWithFailure();
        end else if (clocks != expectClocks) begin
            $display("ERR pins change into %s: expected clock 0x%0h, actual 0x%0h",
                     nextPhase, expectClocks, clocks);
            stopWithFailure();
        end
    endtask

    task automatic runSequence();
        timePhase("PowerSettle", expectedPins(0), PowerOffTicksTb * ClkDivTb);
        timePhase("ClkHigh", expectedPins(OffEnd), SettleTicksTb * ClkDivTb);
        timePhase("ClkLow", expectedPins(SettleEnd), PulseTicksTb * ClkDivTb);
        // Release keeps the ClkLow levels for its single tick
        timePhase("Sample", expectedPins(HighEnd), (PulseTicksTb + 1) * ClkDivTb);
        repeat (SampleTicks * ClkDivTb) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (sdClkRises != 1) begin
            $display("ERR sdClk rising edges: expected 0x1, actual 0x%0h", sdClkRises);
            stopWithFailure();
        end
    endtask

    // Reset pulse in the middle of Sample
    task automatic resetInSample();
        reset <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        checkPins(OffPinsExp, pins);
        checkLed(3'b111, led);
        repeat (ResetCycles - 1) begin
            @(posedge clk);
        end
        releaseReset();
    endtask

    // ==========================================================
    // Main flow
    // ==========================================================

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) begin
            @(posedge clk);
        end
        releaseReset();
        runSequence();

        resetInSample();
        runSequence();

        @(posedge clk);
        if (led0Changes > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("LED 0 never followed a change of DAT2 in Sample");
            stopWithFailure();
        end
    end

endmodule

// File: sdProbe.f
sdProbePkg.sv
sdTickGen.sv
sdPowerSequencer.sv
sdProbeTop.sv
sdProbeTb.sv

// File: Makefile
# Verilator build and run for the sdProbe testbench
#
#   make compile   build the simulation binary
#   make run       run it, fails unless the pass message is printed
#   make clean     remove build output

VERILATOR ?= verilator
TOP       ?= sdProbeTb
FILELIST  ?= sdProbe.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --binary --timing --timescale $(TIMESCALE)
PASS_MSG  ?= Testbench passed

SOURCES   := $(shell cat $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Simulation did not report a pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
